// ==== design/spw_rx_pkg.sv ====
// Shared receiver types and sizes; register offsets assume a 4-bit, word-aligned AXI4-Lite space
`default_nettype none

package spw_rx_pkg;

	// ------------------------------------------------------------------
	// Character and token types
	// ------------------------------------------------------------------
	typedef logic [7:0] spw_byte_t;

	// Bits 7:0 byte, bit 8 end marker, bit 9 error end
	typedef logic [9:0] fifo_entry_t;

	typedef enum logic [2:0] {
		TOK_FCT      = 3'd0,
		TOK_EOP      = 3'd1,
		TOK_EEP      = 3'd2,
		TOK_NCHAR    = 3'd3,
		TOK_NULL     = 3'd4,
		TOK_TIMECODE = 3'd5,
		TOK_ESC_ERR  = 3'd6
	} token_kind_e;

	typedef enum logic [1:0] {
		PARITY,
		FLAG,
		CTRL_BITS,
		DATA_BITS
	} char_state_e;

	// Control codes in transmission order, first bit on the left
	localparam logic [1:0] CTRL_FCT = 2'b00;
	localparam logic [1:0] CTRL_EOP = 2'b01;
	localparam logic [1:0] CTRL_EEP = 2'b10;
	localparam logic [1:0] CTRL_ESC = 2'b11;

	// ------------------------------------------------------------------
	// FIFO sizing
	// ------------------------------------------------------------------
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW    = 4;

	typedef logic [FIFO_AW-1:0] fifo_ptr_t;
	typedef logic [FIFO_AW:0]   fifo_level_t;

	// ------------------------------------------------------------------
	// Host port
	// ------------------------------------------------------------------
	typedef logic [3:0]  axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [3:0]  axil_strb_t;
	typedef logic [1:0]  axil_resp_t;
	typedef logic [15:0] tok_count_t;

	localparam axil_resp_t RESP_OKAY   = 2'b00;
	localparam axil_resp_t RESP_SLVERR = 2'b10;

	localparam axil_addr_t REG_STATUS   = 4'h0;
	localparam axil_addr_t REG_RXDATA   = 4'h4;
	localparam axil_addr_t REG_TIMECODE = 4'h8;
	localparam axil_addr_t REG_COUNTS   = 4'hC;

endpackage

`default_nettype wire

// ==== design/spw_token_if.sv ====
// One decoded token per valid pulse; there is no ready, so sinks must take every token
`default_nettype none
`timescale 1ns/1ps

interface spw_token_if;
	import spw_rx_pkg::*;

	logic        valid;
	token_kind_e kind;
	spw_byte_t   data;
	logic        parity_error;

	modport detector (
		output valid,
		output kind,
		output data,
		output parity_error
	);

	modport sink (
		input valid,
		input kind,
		input data,
		input parity_error
	);

endinterface

`default_nettype wire

// ==== design/ds_bit_sampler.sv ====
// Oversampling DS decoder; the bit period must be at least 3 negedge_clk cycles
`default_nettype none
`timescale 1ns/1ps

module ds_bit_sampler (
	input  logic negedge_clk,
	input  logic rx_resetn,
	input  logic rx_din,
	input  logic rx_sin,
	output logic bit_valid,
	output logic bit_value,
	output logic got_bit
);

	// Two-stage synchronizers, index 1 is the settled sample
	logic [1:0] din_sync;
	logic [1:0] sin_sync;
	logic       ds_xor_q;
	logic       ds_xor;
	logic       ds_change;

	assign ds_xor    = din_sync[1] ^ sin_sync[1];
	assign ds_change = ds_xor != ds_xor_q;

	// ------------------------------------------------------------------
	// Synchronize and detect transitions
	// ------------------------------------------------------------------
	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			din_sync  <= 2'b00;
			sin_sync  <= 2'b00;
			ds_xor_q  <= 1'b0;
			bit_valid <= 1'b0;
			got_bit   <= 1'b0;
		end
		else
		begin
			din_sync  <= {din_sync[0], rx_din};
			sin_sync  <= {sin_sync[0], rx_sin};
			ds_xor_q  <= ds_xor;
			bit_valid <= ds_change;
			// Sticky once the link has toggled
			if (ds_change)
			begin
				got_bit <= 1'b1;
			end
		end
	end

	// Bit value is the data line at the transition
	always_ff @(posedge negedge_clk)
	begin
		bit_value <= din_sync[1];
	end

endmodule

`default_nettype wire

// ==== design/token_detector.sv ====
// Assumes the first received bit is a parity bit; control codes are matched in transmission order
`default_nettype none
`timescale 1ns/1ps

module token_detector (
	input  logic        negedge_clk,
	input  logic        rx_resetn,
	input  logic        bit_valid,
	input  logic        bit_value,
	spw_token_if.detector tok
);
	import spw_rx_pkg::*;

	char_state_e state;
	logic [2:0]  bit_cnt;
	logic [7:0]  shift_q;
	logic        parity_q;
	// XOR of the data or control bits of the previous character
	logic        prev_xor;
	logic        char_perr;
	logic        esc_pending;
	logic        esc_perr;

	logic [1:0]  ctrl_code;
	spw_byte_t   data_byte;
	logic        ctrl_done;
	logic        data_done;
	logic        emit;
	token_kind_e next_kind;

	// Shift register fills from the top, so data lands LSB first
	assign ctrl_code = {shift_q[7], bit_value};
	assign data_byte = {bit_value, shift_q[7:1]};
	assign ctrl_done = bit_valid && (state == CTRL_BITS) && (bit_cnt == 3'd1);
	assign data_done = bit_valid && (state == DATA_BITS) && (bit_cnt == 3'd7);

	// ------------------------------------------------------------------
	// Token classification
	// ------------------------------------------------------------------
	always_comb
	begin
		emit      = 1'b0;
		next_kind = TOK_FCT;
		if (ctrl_done)
		begin
			emit = 1'b1;
			case (ctrl_code)
				CTRL_FCT: next_kind = esc_pending ? TOK_NULL : TOK_FCT;
				CTRL_EOP: next_kind = esc_pending ? TOK_ESC_ERR : TOK_EOP;
				CTRL_EEP: next_kind = esc_pending ? TOK_ESC_ERR : TOK_EEP;
				default:
				begin
					// Lone ESC waits for the next character
					next_kind = TOK_ESC_ERR;
					emit      = esc_pending;
				end
			endcase
		end
		else if (data_done)
		begin
			emit      = 1'b1;
			next_kind = esc_pending ? TOK_TIMECODE : TOK_NCHAR;
		end
	end

	// ------------------------------------------------------------------
	// Character assembly FSM
	// ------------------------------------------------------------------
	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			state       <= PARITY;
			bit_cnt     <= 3'd0;
			parity_q    <= 1'b0;
			prev_xor    <= 1'b0;
			char_perr   <= 1'b0;
			esc_pending <= 1'b0;
			esc_perr    <= 1'b0;
			tok.valid   <= 1'b0;
		end
		else
		begin
			tok.valid <= emit;
			if (bit_valid)
			begin
				case (state)
					PARITY:
					begin
						parity_q <= bit_value;
						state    <= FLAG;
					end
					FLAG:
					begin
						// Parity, flag and previous bits must give odd parity
						char_perr <= ~(parity_q ^ bit_value ^ prev_xor);
						bit_cnt   <= 3'd0;
						state     <= bit_value ? CTRL_BITS : DATA_BITS;
					end
					CTRL_BITS:
					begin
						bit_cnt <= bit_cnt + 3'd1;
						if (ctrl_done)
						begin
							prev_xor    <= ^ctrl_code;
							esc_pending <= (ctrl_code == CTRL_ESC) && !esc_pending;
							esc_perr    <= char_perr;
							state       <= PARITY;
						end
					end
					default:
					begin
						bit_cnt <= bit_cnt + 3'd1;
						if (data_done)
						begin
							prev_xor    <= ^data_byte;
							esc_pending <= 1'b0;
							state       <= PARITY;
						end
					end
				endcase
			end
		end
	end

	// Payload side of the token
	always_ff @(posedge negedge_clk)
	begin
		if (bit_valid)
		begin
			shift_q <= {bit_value, shift_q[7:1]};
		end
		if (emit)
		begin
			tok.kind         <= next_kind;
			tok.data         <= data_done ? data_byte : 8'h00;
			tok.parity_error <= char_perr | (esc_pending & esc_perr);
		end
	end

endmodule

`default_nettype wire

// ==== design/rx_token_fifo.sv ====
// Show-ahead FIFO; writes into a full FIFO are dropped even when a pop happens in the same cycle
`default_nettype none
`timescale 1ns/1ps

module rx_token_fifo (
	input  logic                    negedge_clk,
	input  logic                    rx_resetn,
	input  logic                    pop,
	spw_token_if.sink               tok,
	output spw_rx_pkg::fifo_entry_t rd_data,
	output spw_rx_pkg::fifo_level_t level,
	output logic                    overflow
);
	import spw_rx_pkg::*;

	fifo_entry_t mem [FIFO_DEPTH];
	fifo_ptr_t   wr_ptr;
	fifo_ptr_t   rd_ptr;
	fifo_level_t count;
	fifo_entry_t wr_entry;
	logic        tok_store;
	logic        do_write;
	logic        do_pop;

	// Only data characters and packet ends are stored
	always_comb
	begin
		tok_store = tok.valid && (tok.kind inside {TOK_NCHAR, TOK_EOP, TOK_EEP});
		case (tok.kind)
			TOK_EOP: wr_entry = {1'b0, 1'b1, 8'h00};
			TOK_EEP: wr_entry = {1'b1, 1'b1, 8'h00};
			default: wr_entry = {2'b00, tok.data};
		endcase
	end

	assign do_write = tok_store && (count != fifo_level_t'(FIFO_DEPTH));
	assign do_pop   = pop && (count != '0);
	assign rd_data  = mem[rd_ptr];
	assign level    = count;

	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (do_write)
			begin
				wr_ptr <= wr_ptr + fifo_ptr_t'(1);
			end
			if (do_pop)
			begin
				rd_ptr <= rd_ptr + fifo_ptr_t'(1);
			end
			count    <= count + fifo_level_t'(do_write) - fifo_level_t'(do_pop);
			overflow <= tok_store && !do_write;
		end
	end

	always_ff @(posedge negedge_clk)
	begin
		if (do_write)
		begin
			mem[wr_ptr] <= wr_entry;
		end
	end

endmodule

`default_nettype wire

// ==== design/spw_rx_axil_regs.sv ====
// AXI4-Lite slave with one access outstanding per channel; masters must hold valid until ready
`default_nettype none
`timescale 1ns/1ps

module spw_rx_axil_regs (
	input  logic                    negedge_clk,
	input  logic                    rx_resetn,
	input  logic                    got_bit,
	input  spw_rx_pkg::fifo_entry_t rd_data,
	input  spw_rx_pkg::fifo_level_t level,
	input  logic                    overflow,
	spw_token_if.sink               tok,
	output logic                    pop,
	input  spw_rx_pkg::axil_addr_t  awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  spw_rx_pkg::axil_data_t  wdata,
	input  spw_rx_pkg::axil_strb_t  wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	output spw_rx_pkg::axil_resp_t  bresp,
	output logic                    bvalid,
	input  logic                    bready,
	input  spw_rx_pkg::axil_addr_t  araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output spw_rx_pkg::axil_data_t  rdata,
	output spw_rx_pkg::axil_resp_t  rresp,
	output logic                    rvalid,
	input  logic                    rready
);
	import spw_rx_pkg::*;

	// Sticky flags, in status bit order 4:2 = overflow, escape, parity
	logic [2:0] err_sticky;
	logic [2:0] err_clr;
	logic [2:0] err_set;
	spw_byte_t  tc_value;
	logic       tc_new;
	tok_count_t fct_cnt;
	tok_count_t null_cnt;
	logic       wr_fire;
	logic       rd_fire;
	logic       not_empty;
	axil_data_t rd_word;
	axil_resp_t rd_resp;

	assign not_empty = level != '0;
	assign wr_fire   = awready && awvalid && wvalid;
	assign arready   = !rvalid;
	assign rd_fire   = arvalid && arready;
	// RXDATA read pops at address acceptance
	assign pop       = rd_fire && (araddr == REG_RXDATA) && not_empty;

	assign err_clr = (wr_fire && awaddr == REG_STATUS && wstrb[0]) ? wdata[4:2] : 3'b000;
	assign err_set = {overflow,
		tok.valid && (tok.kind == TOK_ESC_ERR),
		tok.valid && tok.parity_error};

	// ------------------------------------------------------------------
	// Write channel
	// ------------------------------------------------------------------
	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
		end
		else
		begin
			if (awready)
			begin
				awready <= 1'b0;
				wready  <= 1'b0;
			end
			else if (awvalid && wvalid && !bvalid)
			begin
				awready <= 1'b1;
				wready  <= 1'b1;
			end
			if (wr_fire)
			begin
				bvalid <= 1'b1;
			end
			else if (bready)
			begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge negedge_clk)
	begin
		if (wr_fire)
		begin
			bresp <= (awaddr[1:0] == 2'b00) ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// ------------------------------------------------------------------
	// Status, time code and counters
	// ------------------------------------------------------------------
	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			err_sticky <= 3'b000;
			tc_value   <= 8'h00;
			tc_new     <= 1'b0;
			fct_cnt    <= '0;
			null_cnt   <= '0;
		end
		else
		begin
			// Set wins over a clear in the same cycle
			err_sticky <= (err_sticky & ~err_clr) | err_set;
			if (tok.valid && tok.kind == TOK_TIMECODE)
			begin
				tc_value <= tok.data;
				tc_new   <= 1'b1;
			end
			else if (rd_fire && araddr == REG_TIMECODE)
			begin
				tc_new <= 1'b0;
			end
			if (tok.valid && tok.kind == TOK_FCT)
			begin
				fct_cnt <= fct_cnt + tok_count_t'(1);
			end
			if (tok.valid && tok.kind == TOK_NULL)
			begin
				null_cnt <= null_cnt + tok_count_t'(1);
			end
		end
	end

	// ------------------------------------------------------------------
	// Read channel
	// ------------------------------------------------------------------
	always_comb
	begin
		rd_word = '0;
		rd_resp = RESP_OKAY;
		case (araddr)
			REG_STATUS:   rd_word = {19'd0, level, 3'd0, err_sticky, not_empty, got_bit};
			REG_RXDATA:   rd_word = not_empty ? {1'b1, 21'd0, rd_data} : '0;
			REG_TIMECODE: rd_word = {tc_new, 23'd0, tc_value};
			REG_COUNTS:   rd_word = {null_cnt, fct_cnt};
			default:      rd_resp = RESP_SLVERR;
		endcase
	end

	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			rvalid <= 1'b0;
		end
		else if (rd_fire)
		begin
			rvalid <= 1'b1;
		end
		else if (rready)
		begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge negedge_clk)
	begin
		if (rd_fire)
		begin
			rdata <= rd_word;
			rresp <= rd_resp;
		end
	end

endmodule

`default_nettype wire

// ==== design/spw_rx_top.sv ====
// SpaceWire receive path with host port; single clock domain, no transmitter or link FSM
`default_nettype none
`timescale 1ns/1ps

module spw_rx_top (
	input  logic                   negedge_clk,
	input  logic                   rx_resetn,
	input  logic                   rx_din,
	input  logic                   rx_sin,
	input  spw_rx_pkg::axil_addr_t s_axil_awaddr,
	input  logic                   s_axil_awvalid,
	output logic                   s_axil_awready,
	input  spw_rx_pkg::axil_data_t s_axil_wdata,
	input  spw_rx_pkg::axil_strb_t s_axil_wstrb,
	input  logic                   s_axil_wvalid,
	output logic                   s_axil_wready,
	output spw_rx_pkg::axil_resp_t s_axil_bresp,
	output logic                   s_axil_bvalid,
	input  logic                   s_axil_bready,
	input  spw_rx_pkg::axil_addr_t s_axil_araddr,
	input  logic                   s_axil_arvalid,
	output logic                   s_axil_arready,
	output spw_rx_pkg::axil_data_t s_axil_rdata,
	output spw_rx_pkg::axil_resp_t s_axil_rresp,
	output logic                   s_axil_rvalid,
	input  logic                   s_axil_rready
);
	import spw_rx_pkg::*;

	logic        bit_valid;
	logic        bit_value;
	logic        got_bit;
	logic        pop;
	logic        overflow;
	fifo_entry_t rd_data;
	fifo_level_t level;

	spw_token_if tok_if ();

	ds_bit_sampler ds_bit_sampler_i (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.rx_din      (rx_din),
		.rx_sin      (rx_sin),
		.bit_valid   (bit_valid),
		.bit_value   (bit_value),
		.got_bit     (got_bit)
	);

	token_detector token_detector_i (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.bit_valid   (bit_valid),
		.bit_value   (bit_value),
		.tok         (tok_if.detector)
	);

	// FIFO and registers both watch the same token stream
	rx_token_fifo rx_token_fifo_i (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.pop         (pop),
		.tok         (tok_if.sink),
		.rd_data     (rd_data),
		.level       (level),
		.overflow    (overflow)
	);

	spw_rx_axil_regs spw_rx_axil_regs_i (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.got_bit     (got_bit),
		.rd_data     (rd_data),
		.level       (level),
		.overflow    (overflow),
		.tok         (tok_if.sink),
		.pop         (pop),
		.awaddr      (s_axil_awaddr),
		.awvalid     (s_axil_awvalid),
		.awready     (s_axil_awready),
		.wdata       (s_axil_wdata),
		.wstrb       (s_axil_wstrb),
		.wvalid      (s_axil_wvalid),
		.wready      (s_axil_wready),
		.bresp       (s_axil_bresp),
		.bvalid      (s_axil_bvalid),
		.bready      (s_axil_bready),
		.araddr      (s_axil_araddr),
		.arvalid     (s_axil_arvalid),
		.arready     (s_axil_arready),
		.rdata       (s_axil_rdata),
		.rresp       (s_axil_rresp),
		.rvalid      (s_axil_rvalid),
		.rready      (s_axil_rready)
	);

endmodule

`default_nettype wire

// ==== test/spw_rx_sva.sv ====
// Host port and token stream checks; assumes a single outstanding access on each AXI channel
`default_nettype none
`timescale 1ns/1ps

module spw_rx_sva (
	input logic                   negedge_clk,
	input logic                   rx_resetn,
	input logic                   bvalid,
	input logic                   bready,
	input logic                   rvalid,
	input logic                   rready,
	input spw_rx_pkg::axil_resp_t rresp,
	input logic                   tok_valid
);
	import spw_rx_pkg::*;

	// Responses stay up until the master takes them
	b_hold: assert property (@(posedge negedge_clk) disable iff (!rx_resetn)
		bvalid && !bready |=> bvalid)
	else
		$error("bvalid dropped before bready");

	r_hold: assert property (@(posedge negedge_clk) disable iff (!rx_resetn)
		rvalid && !rready |=> rvalid)
	else
		$error("rvalid dropped before rready");

	// A token takes at least four bits, so pulses never touch
	tok_gap: assert property (@(posedge negedge_clk) disable iff (!rx_resetn)
		tok_valid |=> !tok_valid)
	else
		$error("token valid on two consecutive cycles");

	r_resp_legal: assert property (@(posedge negedge_clk) disable iff (!rx_resetn)
		rvalid |-> (rresp == RESP_OKAY || rresp == RESP_SLVERR))
	else
		$error("rresp is neither OKAY nor SLVERR");

endmodule

bind spw_rx_axil_regs spw_rx_sva spw_rx_sva_i (
	.negedge_clk (negedge_clk),
	.rx_resetn   (rx_resetn),
	.bvalid      (bvalid),
	.bready      (bready),
	.rvalid      (rvalid),
	.rready      (rready),
	.rresp       (rresp),
	.tok_valid   (tok.valid)
);

`default_nettype wire

// ==== test/spw_rx_tb.sv ====
// Trace-driven testbench; run from the project root so the trace path resolves, bit period 3 to 6 clocks
`default_nettype none
`timescale 1ns/1ps

module spw_rx_tb;
	import spw_rx_pkg::*;

	localparam int WAIT_LIMIT    = 200;
	localparam int SETTLE_CYCLES = 8;

	logic       negedge_clk;
	logic       rx_resetn;
	logic       rx_din;
	logic       rx_sin;
	axil_addr_t s_axil_awaddr;
	logic       s_axil_awvalid;
	logic       s_axil_awready;
	axil_data_t s_axil_wdata;
	axil_strb_t s_axil_wstrb;
	logic       s_axil_wvalid;
	logic       s_axil_wready;
	axil_resp_t s_axil_bresp;
	logic       s_axil_bvalid;
	logic       s_axil_bready;
	axil_addr_t s_axil_araddr;
	logic       s_axil_arvalid;
	logic       s_axil_arready;
	axil_data_t s_axil_rdata;
	axil_resp_t s_axil_rresp;
	logic       s_axil_rvalid;
	logic       s_axil_rready;

	int   errors;
	int   checks;
	logic aborted;

	spw_rx_top spw_rx_top_i (.*);

	always #20 negedge_clk = ~negedge_clk;

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		aborted = 1'b1;
		$display("Timed out waiting for %s", what);
	endtask

	// ------------------------------------------------------------------
	// DS encoder where data follows the bit and strobe toggles on a repeat
	// ------------------------------------------------------------------
	task automatic send_bits(input string bits);
		int   period;
		byte  c;
		logic bit_now;
		for (int i = 0; i < bits.len(); i++)
		begin
			c = bits.getc(i);
			if (c == "0" || c == "1")
			begin
				bit_now = (c == "1");
				if (bit_now != rx_din)
					rx_din = bit_now;
				else
					rx_sin = ~rx_sin;
				period = 3 + ($urandom % 4);
				repeat (period) @(posedge negedge_clk);
				#2;
			end
		end
		// Sampler, detector and FIFO need five cycles after the last edge
		repeat (SETTLE_CYCLES) @(posedge negedge_clk);
		#2;
	endtask

	// ------------------------------------------------------------------
	// AXI4-Lite master
	// ------------------------------------------------------------------
	task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
		output axil_resp_t resp);
		int n;
		resp           = RESP_OKAY;
		s_axil_awaddr  = addr;
		s_axil_wdata   = data;
		s_axil_wstrb   = 4'hF;
		s_axil_awvalid = 1'b1;
		s_axil_wvalid  = 1'b1;
		s_axil_bready  = 1'b0;
		n = 0;
		while (!(s_axil_awready && s_axil_wready) && n < WAIT_LIMIT)
		begin
			@(negedge negedge_clk);
			n++;
		end
		if (!(s_axil_awready && s_axil_wready))
		begin
			s_axil_awvalid = 1'b0;
			s_axil_wvalid  = 1'b0;
			report_timeout("awready and wready");
			return;
		end
		@(posedge negedge_clk);
		#2;
		s_axil_awvalid = 1'b0;
		s_axil_wvalid  = 1'b0;
		n = 0;
		while (!s_axil_bvalid && n < WAIT_LIMIT)
		begin
			@(negedge negedge_clk);
			n++;
		end
		if (!s_axil_bvalid)
		begin
			report_timeout("bvalid");
			return;
		end
		resp = s_axil_bresp;
		// Response has to hold for a cycle with bready low
		@(posedge negedge_clk);
		#2;
		s_axil_bready = 1'b1;
		@(posedge negedge_clk);
		#2;
		s_axil_bready = 1'b0;
	endtask

	task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
		output axil_resp_t resp);
		int n;
		data           = '0;
		resp           = RESP_OKAY;
		s_axil_araddr  = addr;
		s_axil_arvalid = 1'b1;
		s_axil_rready  = 1'b0;
		n = 0;
		while (!s_axil_arready && n < WAIT_LIMIT)
		begin
			@(negedge negedge_clk);
			n++;
		end
		if (!s_axil_arready)
		begin
			s_axil_arvalid = 1'b0;
			report_timeout("arready");
			return;
		end
		@(posedge negedge_clk);
		#2;
		s_axil_arvalid = 1'b0;
		n = 0;
		while (!s_axil_rvalid && n < WAIT_LIMIT)
		begin
			@(negedge negedge_clk);
			n++;
		end
		if (!s_axil_rvalid)
		begin
			report_timeout("rvalid");
			return;
		end
		data = s_axil_rdata;
		resp = s_axil_rresp;
		// Read data has to hold for a cycle with rready low
		@(posedge negedge_clk);
		#2;
		s_axil_rready = 1'b1;
		@(posedge negedge_clk);
		#2;
		s_axil_rready = 1'b0;
	endtask

	// Polls STATUS bit 1
	task automatic wait_not_empty();
		int         n;
		axil_data_t data;
		axil_resp_t resp;
		n    = 0;
		data = '0;
		while (!data[1] && n < WAIT_LIMIT && !aborted)
		begin
			axil_read(REG_STATUS, data, resp);
			n++;
		end
		if (!data[1] && !aborted)
			report_timeout("the FIFO not-empty flag");
	endtask

	// ------------------------------------------------------------------
	// Trace interpreter
	// ------------------------------------------------------------------
	task automatic run_line(input string line);
		byte         kind;
		int          fields;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] resp;
		axil_data_t  got_data;
		axil_resp_t  got_resp;
		kind = line.getc(0);
		if (kind == "B")
			send_bits(line.substr(1, line.len() - 1));
		else if (kind == "N")
			wait_not_empty();
		else if (kind == "W" || kind == "R")
		begin
			fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", addr, data, resp);
			if (fields != 3)
			begin
				aborted = 1'b1;
				$display("Malformed trace line: %s", line);
			end
			else if (kind == "W")
			begin
				axil_write(addr[3:0], data, got_resp);
				if (!aborted)
					check_value("s_axil_bresp", {30'd0, got_resp}, resp);
			end
			else
			begin
				axil_read(addr[3:0], got_data, got_resp);
				if (!aborted)
				begin
					check_value("s_axil_rdata", got_data, data);
					check_value("s_axil_rresp", {30'd0, got_resp}, resp);
				end
			end
		end
	endtask

	initial
	begin
		string line;
		int    fd;
		int    got;
		void'($urandom(32'h0922_cfa8));
		negedge_clk    = 1'b0;
		rx_resetn      = 1'b0;
		rx_din         = 1'b0;
		rx_sin         = 1'b0;
		s_axil_awaddr  = '0;
		s_axil_awvalid = 1'b0;
		s_axil_wdata   = '0;
		s_axil_wstrb   = '0;
		s_axil_wvalid  = 1'b0;
		s_axil_bready  = 1'b0;
		s_axil_araddr  = '0;
		s_axil_arvalid = 1'b0;
		s_axil_rready  = 1'b0;
		errors         = 0;
		checks         = 0;
		aborted        = 1'b0;
		repeat (3) @(posedge negedge_clk);
		#2;
		rx_resetn = 1'b1;
		fd = $fopen("test/spw_rx_trace.txt", "r");
		if (fd == 0)
		begin
			aborted = 1'b1;
			$display("Could not open the trace file");
		end
		else
		begin
			while (!aborted && !$feof(fd))
			begin
				got = $fgets(line, fd);
				if (got > 0)
					run_line(line);
			end
			$fclose(fd);
		end
		$display("checks %0d errors %0d aborted %0d", checks, errors, aborted);
		if (errors == 0 && !aborted)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/spw_rx_trace.txt ====
# B bits: DS-encoded bit string, _ between characters | N: wait for FIFO not empty
# W addr data bresp | R addr rdata rresp (all hex)
# Two NULLs, N-chars 5A and C3, EOP
B 0111_0100_0111_0100
B 1001011010_1011000011_0101
N
R 4 8000005A 0
R 4 800000C3 0
R 4 80000100 0
R 4 00000000 0
# FCT NULL FCT NULL FCT; counts include the earlier NULLs
B 1100_01110100_0100_01110100_0100
R C 00040003 0
# Time code 2B
B 0111_1011010100
R 8 8000002B 0
R 8 0000002B 0
# FCT with flipped parity, then ESC followed by EOP
B 1100
R 0 00000005 0
W 0 00000004 0
R 0 00000001 0
B 0111_0101
R 0 00000009 0
W 0 0000001C 0
# Eighteen N-chars 00 11 .. FF 03 05, last two dropped
B 0000000000_1010001000_1001000100_1011001100_1000100010_1010101010
B 1001100110_1011101110_1000010001_1010011001_1001010101_1011011101
B 1000110011_1010111011_1001110111_1011111111_1011000000_1010100000
R 0 00001013 0
R 4 80000000 0
R 4 80000011 0
R 4 80000022 0
R 4 80000033 0
R 4 80000044 0
R 4 80000055 0
R 4 80000066 0
R 4 80000077 0
R 4 80000088 0
R 4 80000099 0
R 4 800000AA 0
R 4 800000BB 0
R 4 800000CC 0
R 4 800000DD 0
R 4 800000EE 0
R 4 800000FF 0
R 4 00000000 0
# Unmapped read, write to the read-only time code
R 2 00000000 2
W 8 000000AA 0
R 8 0000002B 0

// ==== sources.f ====
design/spw_rx_pkg.sv
design/spw_token_if.sv
design/ds_bit_sampler.sv
design/token_detector.sv
design/rx_token_fifo.sv
design/spw_rx_axil_regs.sv
design/spw_rx_top.sv
test/spw_rx_sva.sv
test/spw_rx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module spw_rx_tb \
	-f sources.f -Mdir obj_dir -o spw_rx_sim

./obj_dir/spw_rx_sim | tee sim.log

if grep -qx "test passed" sim.log
then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
